// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run csr_unit_tb, check $(LOG)"
	@echo "  clean  remove build output and $(LOG)"

test:
	verilator --binary --timing --assert -f csr_sys.f --top-module csr_unit_tb -Mdir obj_dir
	./obj_dir/Vcsr_unit_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: csr_sys.f
+incdir+include
rtl/priv_pkg.sv
rtl/csr_pkg.sv
rtl/csr_alu.sv
rtl/csr_regfile.sv
rtl/trap_ctrl.sv
rtl/csr_unit.sv
tb/csr_unit_assertions.sv
tb/csr_unit_tb.sv

// File: include/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// data width set by misa.MXL
`define XLEN 32

////////////////////////////////////////////////////////////
// machine CSR addresses
////////////////////////////////////////////////////////////
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MIP       12'h344
`define CSR_MVENDORID 12'hf11
`define CSR_MARCHID   12'hf12
`define CSR_MIMPID    12'hf13
`define CSR_MHARTID   12'hf14

// MXL 1 for 32 bit with extensions I and M
`define MISA_VALUE 32'h4000_1100

// interrupt cause codes without the bit 31 flag
`define CAUSE_M_EXT_IRQ   31'd11
`define CAUSE_M_TIMER_IRQ 31'd7

// field positions in mstatus, mie and mip
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7
`define MSTATUS_MPP  11  // low bit of the 2-bit field
`define IRQ_BIT_MEI  11
`define IRQ_BIT_MTI  7

`endif

// File: rtl/csr_alu.sv
`default_nettype none

// write-back value of a CSR instruction
module csr_alu
(
    input  csr_pkg::csr_op_t op,
    input  csr_pkg::xlen_t   old_value,
    input  csr_pkg::xlen_t   operand,
    output csr_pkg::xlen_t   wdata,
    output logic             we
);

    always_comb
    begin
        wdata = old_value;
        we    = 1'b0;
        case (op)
            csr_pkg::CSR_OP_WRITE:
            begin
                wdata = operand;
                we    = 1'b1;  // csrrw always writes
            end
            csr_pkg::CSR_OP_SET:
            begin
                wdata = old_value | operand;
                we    = |operand;  // zero source means read only
            end
            csr_pkg::CSR_OP_CLEAR:
            begin
                wdata = old_value & ~operand;
                we    = |operand;
            end
            default:
            begin
                // plain read
                wdata = old_value;
                we    = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/csr_pkg.sv
`default_nettype none

`include "csr_defines.svh"

package csr_pkg;

    ////////////////////////////////////////////////////////////
    // CSR access path
    ////////////////////////////////////////////////////////////

    typedef logic [11:0]        csr_addr_t;  // 12-bit CSR address
    typedef logic [`XLEN-1:0]   xlen_t;      // CSR data and pc values
    typedef logic [1:0]         csr_op_t;

    // operation encodings
    localparam csr_op_t CSR_OP_READ  = 2'd0;  // read without write-back
    localparam csr_op_t CSR_OP_WRITE = 2'd1;  // csrrw
    localparam csr_op_t CSR_OP_SET   = 2'd2;  // csrrs
    localparam csr_op_t CSR_OP_CLEAR = 2'd3;  // csrrc

endpackage

`default_nettype wire

// File: rtl/csr_regfile.sv
`default_nettype none

`include "csr_defines.svh"

module csr_regfile
(
    input  logic                clk,
    input  logic                nrst,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  logic                csr_we,
    input  csr_pkg::xlen_t      csr_wdata,
    input  logic                trap_enter,
    input  priv_pkg::cause_t    trap_cause,
    input  csr_pkg::xlen_t      trap_pc,
    input  csr_pkg::xlen_t      trap_tval,
    input  logic                mret_commit,
    input  logic                m_ext_irq,
    input  logic                m_timer_irq,
    output csr_pkg::xlen_t      csr_rdata,
    output logic                m_eie,
    output logic                m_tie,
    output csr_pkg::xlen_t      mtvec_value,
    output csr_pkg::xlen_t      mepc_value,
    output priv_pkg::mode_t     current_mode
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    // mstatus fields
    logic               st_mie;
    logic               st_mpie;
    priv_pkg::mode_t    st_mpp;

    // mie fields
    logic               meie;
    logic               mtie;

    logic [`XLEN-1:2]   mtvec_base;  // direct mode only
    logic [`XLEN-1:2]   mepc_word;
    priv_pkg::cause_t   mcause;
    csr_pkg::xlen_t     mtval;
    csr_pkg::xlen_t     mscratch;

    // assembled views
    csr_pkg::xlen_t     mstatus_val;
    csr_pkg::xlen_t     mie_val;
    csr_pkg::xlen_t     mip_val;

    always_comb
    begin
        mstatus_val = '0;
        mstatus_val[`MSTATUS_MIE]  = st_mie;
        mstatus_val[`MSTATUS_MPIE] = st_mpie;
        mstatus_val[`MSTATUS_MPP +: 2] = st_mpp;

        mie_val = '0;
        mie_val[`IRQ_BIT_MEI] = meie;
        mie_val[`IRQ_BIT_MTI] = mtie;

        // pending bits follow the input levels
        mip_val = '0;
        mip_val[`IRQ_BIT_MEI] = m_ext_irq;
        mip_val[`IRQ_BIT_MTI] = m_timer_irq;
    end

    ////////////////////////////////////////////////////////////
    // read mux
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (csr_addr)
            `CSR_MISA:      csr_rdata = `MISA_VALUE;
            `CSR_MVENDORID,
            `CSR_MARCHID,
            `CSR_MIMPID,
            `CSR_MHARTID:   csr_rdata = '0;  // single hart without ids
            `CSR_MSTATUS:   csr_rdata = mstatus_val;
            `CSR_MIE:       csr_rdata = mie_val;
            `CSR_MIP:       csr_rdata = mip_val;
            `CSR_MTVEC:     csr_rdata = mtvec_value;
            `CSR_MEPC:      csr_rdata = mepc_value;
            `CSR_MCAUSE:    csr_rdata = mcause;
            `CSR_MTVAL:     csr_rdata = mtval;
            `CSR_MSCRATCH:  csr_rdata = mscratch;
            default:        csr_rdata = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            current_mode <= priv_pkg::MODE_M;
            st_mie       <= 1'b0;
            st_mpie      <= 1'b0;
            st_mpp       <= priv_pkg::MODE_U;
            meie         <= 1'b0;
            mtie         <= 1'b0;
            mtvec_base   <= '0;
            mepc_word    <= '0;
            mcause       <= '0;
            mtval        <= '0;
            mscratch     <= '0;
        end
        else if (trap_enter)
        begin
            // trap entry stacks MIE and the mode
            st_mpie      <= st_mie;
            st_mie       <= 1'b0;
            st_mpp       <= current_mode;
            current_mode <= priv_pkg::MODE_M;
            mepc_word    <= trap_pc[`XLEN-1:2];
            mcause       <= trap_cause;
            mtval        <= trap_tval;
        end
        else if (mret_commit)
        begin
            st_mie       <= st_mpie;
            st_mpie      <= 1'b1;
            current_mode <= st_mpp;
            st_mpp       <= priv_pkg::MODE_U;  // least privileged mode
        end
        else if (csr_we)
        begin
            case (csr_addr)
                `CSR_MSTATUS:
                begin
                    st_mie  <= csr_wdata[`MSTATUS_MIE];
                    st_mpie <= csr_wdata[`MSTATUS_MPIE];
                    // only M and U are legal in MPP
                    st_mpp  <= (csr_wdata[`MSTATUS_MPP +: 2] == 2'b11) ?
                               priv_pkg::MODE_M : priv_pkg::MODE_U;
                end
                `CSR_MIE:
                begin
                    meie <= csr_wdata[`IRQ_BIT_MEI];
                    mtie <= csr_wdata[`IRQ_BIT_MTI];
                end
                `CSR_MTVEC:    mtvec_base <= csr_wdata[`XLEN-1:2];
                `CSR_MEPC:     mepc_word  <= csr_wdata[`XLEN-1:2];
                `CSR_MCAUSE:   mcause     <= csr_wdata;
                `CSR_MTVAL:    mtval      <= csr_wdata;
                `CSR_MSCRATCH: mscratch   <= csr_wdata;
                default:
                begin
                    // mip and the identity registers ignore writes
                end
            endcase
        end
    end

    assign mtvec_value = {mtvec_base, 2'b00};
    assign mepc_value  = {mepc_word, 2'b00};

    // enables gated by the global MIE
    assign m_eie = meie & st_mie;
    assign m_tie = mtie & st_mie;

endmodule

`default_nettype wire

// File: rtl/csr_unit.sv
`default_nettype none

module csr_unit
(
    input  logic                clk,
    input  logic                nrst,
    input  logic                csr_valid,
    input  csr_pkg::csr_op_t    csr_op,
    input  csr_pkg::csr_addr_t  csr_addr,
    input  csr_pkg::xlen_t      csr_operand,
    input  logic                exc_valid,
    input  priv_pkg::cause_t    exc_cause,
    input  csr_pkg::xlen_t      exc_pc,
    input  csr_pkg::xlen_t      next_pc,
    input  csr_pkg::xlen_t      exc_tval,
    input  logic                mret,
    input  logic                stall,
    input  logic                m_ext_irq,
    input  logic                m_timer_irq,
    output csr_pkg::xlen_t      csr_rdata,
    output logic                trap_taken,
    output logic                redirect_valid,
    output csr_pkg::xlen_t      redirect_pc,
    output priv_pkg::mode_t     current_mode
);

    csr_pkg::xlen_t     alu_wdata;
    logic               alu_we;
    logic               commit_ok;
    logic               csr_we;
    logic               trap_enter;
    priv_pkg::cause_t   trap_cause;
    csr_pkg::xlen_t     trap_pc;
    csr_pkg::xlen_t     trap_tval;
    logic               mret_commit;
    logic               m_eie;
    logic               m_tie;
    csr_pkg::xlen_t     mtvec_value;
    csr_pkg::xlen_t     mepc_value;

    csr_alu u_alu
    (
        .op        (csr_op),
        .old_value (csr_rdata),
        .operand   (csr_operand),
        .wdata     (alu_wdata),
        .we        (alu_we)
    );

    trap_ctrl u_trap
    (
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .exc_pc         (exc_pc),
        .exc_tval       (exc_tval),
        .mret           (mret),
        .stall          (stall),
        .m_ext_irq      (m_ext_irq),
        .m_timer_irq    (m_timer_irq),
        .m_eie          (m_eie),
        .m_tie          (m_tie),
        .mtvec_value    (mtvec_value),
        .mepc_value     (mepc_value),
        .csr_valid      (csr_valid),
        .next_pc        (next_pc),
        .trap_enter     (trap_enter),
        .trap_cause     (trap_cause),
        .trap_pc        (trap_pc),
        .trap_tval      (trap_tval),
        .mret_commit    (mret_commit),
        .commit_ok      (commit_ok),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // csr write only when nothing else owns the cycle
    assign csr_we     = alu_we & commit_ok;
    assign trap_taken = trap_enter;

    csr_regfile u_regfile
    (
        .clk          (clk),
        .nrst         (nrst),
        .csr_addr     (csr_addr),
        .csr_we       (csr_we),
        .csr_wdata    (alu_wdata),
        .trap_enter   (trap_enter),
        .trap_cause   (trap_cause),
        .trap_pc      (trap_pc),
        .trap_tval    (trap_tval),
        .mret_commit  (mret_commit),
        .m_ext_irq    (m_ext_irq),
        .m_timer_irq  (m_timer_irq),
        .csr_rdata    (csr_rdata),
        .m_eie        (m_eie),
        .m_tie        (m_tie),
        .mtvec_value  (mtvec_value),
        .mepc_value   (mepc_value),
        .current_mode (current_mode)
    );

endmodule

`default_nettype wire

// File: rtl/priv_pkg.sv
`default_nettype none

`include "csr_defines.svh"

package priv_pkg;

    ////////////////////////////////////////////////////////////
    // privilege state
    ////////////////////////////////////////////////////////////

    // only M and U exist in this core
    // same encoding is stored in mstatus.MPP
    typedef enum logic [1:0]
    {
        MODE_U = 2'b00,
        MODE_M = 2'b11
    } mode_t;

    // trap cause
    // bit 31 marks an interrupt, the low bits hold the code
    typedef logic [`XLEN-1:0] cause_t;

    // supervisor mode, delegation and counters are not implemented

endpackage

`default_nettype wire

// File: rtl/trap_ctrl.sv
`default_nettype none

`include "csr_defines.svh"

// trap arbitration and redirect
module trap_ctrl
(
    input  logic                exc_valid,
    input  priv_pkg::cause_t    exc_cause,
    input  csr_pkg::xlen_t      exc_pc,
    input  csr_pkg::xlen_t      exc_tval,
    input  logic                mret,
    input  logic                stall,
    input  logic                m_ext_irq,
    input  logic                m_timer_irq,
    input  logic                m_eie,
    input  logic                m_tie,
    input  csr_pkg::xlen_t      mtvec_value,
    input  csr_pkg::xlen_t      mepc_value,
    input  logic                csr_valid,
    input  csr_pkg::xlen_t      next_pc,
    output logic                trap_enter,
    output priv_pkg::cause_t    trap_cause,
    output csr_pkg::xlen_t      trap_pc,
    output csr_pkg::xlen_t      trap_tval,
    output logic                mret_commit,
    output logic                commit_ok,
    output logic                redirect_valid,
    output csr_pkg::xlen_t      redirect_pc
);

    logic ext_pend;
    logic tim_pend;
    logic trap_req;

    assign ext_pend = m_ext_irq & m_eie;
    assign tim_pend = m_timer_irq & m_tie;
    assign trap_req = exc_valid | ext_pend | tim_pend;

    ////////////////////////////////////////////////////////////
    // priority order exception then external then timer
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        if (exc_valid)
        begin
            trap_cause = exc_cause;
            trap_pc    = exc_pc;
            trap_tval  = exc_tval;
        end
        else
        begin
            // interrupts resume at the next instruction
            trap_cause = ext_pend ? {1'b1, `CAUSE_M_EXT_IRQ} : {1'b1, `CAUSE_M_TIMER_IRQ};
            trap_pc    = next_pc;
            trap_tval  = '0;
        end
    end

    assign trap_enter  = trap_req & ~stall;
    assign mret_commit = mret & ~stall & ~trap_req;  // trap wins
    assign commit_ok   = csr_valid & ~stall & ~trap_req;

    assign redirect_valid = trap_enter | mret_commit;
    assign redirect_pc    = trap_enter ? mtvec_value : mepc_value;

endmodule

`default_nettype wire

// File: tb/csr_unit_assertions.sv
`default_nettype none

module csr_unit_assertions
(
    input logic                 clk,
    input logic                 nrst,
    input logic                 stall,
    input logic                 exc_valid,
    input csr_pkg::xlen_t       exc_pc,
    input csr_pkg::csr_op_t     csr_op,
    input csr_pkg::xlen_t       csr_operand,
    input logic                 trap_taken,
    input logic                 redirect_valid,
    input priv_pkg::mode_t      current_mode,
    input csr_pkg::xlen_t       mepc_value,
    input logic                 csr_we
);

    int unsigned fail_count = 0;  // failed assertions so far

    ////////////////////////////////////////////////////////////
    // trap and redirect rules
    ////////////////////////////////////////////////////////////

    a_stall_blocks: assert property (@(posedge clk) disable iff (!nrst)
        stall |-> !trap_taken && !redirect_valid)
        else
        begin
            fail_count++;
            $error("trap or redirect while stalled");
        end

    a_exc_taken: assert property (@(posedge clk) disable iff (!nrst)
        exc_valid && !stall |-> trap_taken)
        else
        begin
            fail_count++;
            $error("exception not taken");
        end

    a_trap_mode: assert property (@(posedge clk) disable iff (!nrst)
        trap_taken |=> current_mode == priv_pkg::MODE_M)
        else
        begin
            fail_count++;
            $error("mode is not M after trap");
        end

    a_exc_epc: assert property (@(posedge clk) disable iff (!nrst)
        trap_taken && exc_valid |=> mepc_value == {$past(exc_pc[31:2]), 2'b00})
        else
        begin
            fail_count++;
            $error("mepc differs from exception pc");
        end

    a_trap_drops_write: assert property (@(posedge clk) disable iff (!nrst)
        trap_taken |-> !csr_we)
        else
        begin
            fail_count++;
            $error("CSR write committed with a trap");
        end

    // no write for a read or for set and clear with a zero source
    a_no_write: assert property (@(posedge clk) disable iff (!nrst)
        csr_op == csr_pkg::CSR_OP_READ
            || (csr_op != csr_pkg::CSR_OP_WRITE && csr_operand == '0)
            |-> !csr_we)
        else
        begin
            fail_count++;
            $error("CSR write enabled for a read-only operation");
        end

    a_reset_quiet: assert property (@(posedge clk)
        !nrst |-> !trap_taken && !redirect_valid)
        else
        begin
            fail_count++;
            $error("trap active during reset");
        end

endmodule

bind csr_unit csr_unit_assertions u_assertions
(
    .clk            (clk),
    .nrst           (nrst),
    .stall          (stall),
    .exc_valid      (exc_valid),
    .exc_pc         (exc_pc),
    .csr_op         (csr_op),
    .csr_operand    (csr_operand),
    .trap_taken     (trap_taken),
    .redirect_valid (redirect_valid),
    .current_mode   (current_mode),
    .mepc_value     (mepc_value),
    .csr_we         (csr_we)
);

`default_nettype wire

// File: tb/csr_unit_tb.sv
`default_nettype none

`include "csr_defines.svh"

module csr_unit_tb;

    // cycle budget per test for the timeout
    localparam int RESET_CYCLES = 16;
    localparam int LEN_RESET    = 14;
    localparam int LEN_OPS      = 60;
    localparam int LEN_MASK     = 40;
    localparam int LEN_EXC      = 24;
    localparam int LEN_IRQ      = 50;
    localparam int LEN_MRET     = 36;
    localparam int TIMEOUT = 4 * (RESET_CYCLES + LEN_RESET + LEN_OPS + LEN_MASK
                                  + LEN_EXC + LEN_IRQ + LEN_MRET);

    logic               clk;
    logic               nrst;
    logic               csr_valid;
    csr_pkg::csr_op_t   csr_op;
    csr_pkg::csr_addr_t csr_addr;
    csr_pkg::xlen_t     csr_operand;
    logic               exc_valid;
    priv_pkg::cause_t   exc_cause;
    csr_pkg::xlen_t     exc_pc;
    csr_pkg::xlen_t     next_pc;
    csr_pkg::xlen_t     exc_tval;
    logic               mret;
    logic               stall;
    logic               m_ext_irq;
    logic               m_timer_irq;
    csr_pkg::xlen_t     csr_rdata;
    logic               trap_taken;
    logic               redirect_valid;
    csr_pkg::xlen_t     redirect_pc;
    priv_pkg::mode_t    current_mode;

    logic [31:0]        lfsr = 32'he83e7537;
    int                 cycle_count = 0;
    int                 error_count = 0;
    int                 check_count = 0;
    int                 test_count = 0;
    int                 test_start_errors = 0;
    string              cur_test;

    // reference model
    logic [31:0]        m_scratch;
    logic [31:0]        m_tval;
    logic [31:0]        m_mtvec;
    logic [31:0]        m_mepc;

    csr_unit dut
    (
        .clk            (clk),
        .nrst           (nrst),
        .csr_valid      (csr_valid),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_operand    (csr_operand),
        .exc_valid      (exc_valid),
        .exc_cause      (exc_cause),
        .exc_pc         (exc_pc),
        .next_pc        (next_pc),
        .exc_tval       (exc_tval),
        .mret           (mret),
        .stall          (stall),
        .m_ext_irq      (m_ext_irq),
        .m_timer_irq    (m_timer_irq),
        .csr_rdata      (csr_rdata),
        .trap_taken     (trap_taken),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .current_mode   (current_mode)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT)
        begin
            $display("timeout after %0d cycles", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        lsb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb)
                lfsr = lfsr ^ 32'ha300_0000;
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        if (exp !== act)
        begin
            error_count++;
            $display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    // one-cycle CSR instruction sampled before the edge
    task automatic csr_cycle(input csr_pkg::csr_op_t op, input logic [11:0] addr,
                             input logic [31:0] val, output logic [31:0] rd);
        @(negedge clk);
        csr_valid   = 1'b1;
        csr_op      = op;
        csr_addr    = addr;
        csr_operand = val;
        #10;
        rd = csr_rdata;
        @(negedge clk);
        csr_valid = 1'b0;
    endtask

    task automatic write_csr(input csr_pkg::csr_op_t op, input logic [11:0] addr,
                             input logic [31:0] val);
        logic [31:0] unused;
        csr_cycle(op, addr, val, unused);
    endtask

    task automatic check_csr(input string what, input logic [11:0] addr,
                             input logic [31:0] exp);
        logic [31:0] rd;
        csr_cycle(csr_pkg::CSR_OP_READ, addr, 32'h0, rd);
        check_value(what, exp, rd);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_start_errors = error_count;
        test_count++;
    endtask

    task automatic end_test;
        $display("test %s done, %0d errors", cur_test, error_count - test_start_errors);
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] op_bits;
        logic [11:0] addr;
        logic [31:0] pc;
        logic [31:0] tval;
        clk         = 1'b0;
        nrst        = 1'b0;
        csr_valid   = 1'b0;
        csr_op      = '0;
        csr_addr    = '0;
        csr_operand = '0;
        exc_valid   = 1'b0;
        exc_cause   = '0;
        exc_pc      = '0;
        next_pc     = '0;
        exc_tval    = '0;
        mret        = 1'b0;
        stall       = 1'b0;
        m_ext_irq   = 1'b0;
        m_timer_irq = 1'b0;
        m_scratch   = '0;
        m_tval      = '0;
        m_mtvec     = '0;
        m_mepc      = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        nrst = 1'b1;

        start_test("reset");
        check_csr("misa", `CSR_MISA, `MISA_VALUE);
        check_csr("mstatus", `CSR_MSTATUS, 32'h0);
        check_csr("mie", `CSR_MIE, 32'h0);
        check_csr("mcause", `CSR_MCAUSE, 32'h0);
        check_value("mode", 32'h3, {30'h0, current_mode});
        check_value("trap_taken", 32'h0, {31'h0, trap_taken});
        end_test();

        start_test("csr_ops");
        for (int i = 0; i < 8; i++)
        begin
            addr = i[0] ? `CSR_MTVAL : `CSR_MSCRATCH;
            op_bits = rand_bits(2);
            if (op_bits[1:0] == 2'd0)
                op_bits = 32'd1;
            r = rand_bits(32);
            pc = i[0] ? m_tval : m_scratch;  // old value
            case (op_bits[1:0])
                2'd1: pc = r;
                2'd2: pc = pc | r;
                default: pc = pc & ~r;
            endcase
            if (i[0])
                m_tval = pc;
            else
                m_scratch = pc;
            write_csr(op_bits[1:0], addr, r);
            check_csr("rmw", addr, pc);
        end
        write_csr(csr_pkg::CSR_OP_SET, `CSR_MSCRATCH, 32'h0);
        check_csr("set zero", `CSR_MSCRATCH, m_scratch);
        write_csr(csr_pkg::CSR_OP_CLEAR, `CSR_MTVAL, 32'h0);
        check_csr("clear zero", `CSR_MTVAL, m_tval);
        end_test();

        start_test("masking");
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MSTATUS, 32'hffff_ffff);
        check_csr("mstatus", `CSR_MSTATUS, 32'h0000_1888);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MSTATUS, 32'h0);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MIE, 32'hffff_ffff);
        check_csr("mie", `CSR_MIE, 32'h0000_0880);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MTVEC, 32'hffff_ffff);
        check_csr("mtvec", `CSR_MTVEC, 32'hffff_fffc);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MEPC, 32'hffff_ffff);
        check_csr("mepc", `CSR_MEPC, 32'hffff_fffc);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MIP, 32'hffff_ffff);
        check_csr("mip", `CSR_MIP, 32'h0);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MISA, 32'h0);
        check_csr("misa", `CSR_MISA, `MISA_VALUE);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MHARTID, 32'hffff_ffff);
        check_csr("mhartid", `CSR_MHARTID, 32'h0);
        end_test();

        ////////////////////////////////////////////////////////////
        // traps
        ////////////////////////////////////////////////////////////

        start_test("exception");
        m_mtvec = rand_bits(32);
        m_mtvec[1:0] = 2'b00;
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MTVEC, m_mtvec);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MSTATUS, 32'h8);
        pc = rand_bits(32);
        tval = rand_bits(32);
        @(negedge clk);
        exc_valid   = 1'b1;
        exc_cause   = 32'd2;
        exc_pc      = pc;
        exc_tval    = tval;
        csr_valid   = 1'b1;
        csr_op      = csr_pkg::CSR_OP_WRITE;
        csr_addr    = `CSR_MSCRATCH;
        csr_operand = ~m_scratch;  // must be dropped
        #10;
        check_value("redirect_valid", 32'h1, {31'h0, redirect_valid});
        check_value("redirect_pc", m_mtvec, redirect_pc);
        @(negedge clk);
        exc_valid = 1'b0;
        csr_valid = 1'b0;
        check_csr("mepc", `CSR_MEPC, {pc[31:2], 2'b00});
        check_csr("mcause", `CSR_MCAUSE, 32'd2);
        check_csr("mtval", `CSR_MTVAL, tval);
        check_csr("mstatus", `CSR_MSTATUS, 32'h0000_1880);  // MPP M with MPIE set
        check_csr("mscratch", `CSR_MSCRATCH, m_scratch);
        end_test();

        start_test("interrupts");
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MSTATUS, 32'h0);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MIE, 32'h0000_0880);
        m_ext_irq = 1'b1;
        m_timer_irq = 1'b1;
        repeat (2) @(negedge clk);
        check_value("masked by MIE", 32'h0, {31'h0, trap_taken});
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MIE, 32'h0);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MSTATUS, 32'h8);
        #10;
        check_value("masked by mie", 32'h0, {31'h0, trap_taken});
        @(negedge clk);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MIE, 32'h0000_0880);
        stall = 1'b1;
        #10;
        check_value("stalled", 32'h0, {31'h0, trap_taken});
        pc = rand_bits(32);
        @(negedge clk);
        stall = 1'b0;
        next_pc = pc;
        #10;
        check_value("taken", 32'h1, {31'h0, trap_taken});
        check_value("redirect_pc", m_mtvec, redirect_pc);
        @(negedge clk);
        m_ext_irq = 1'b0;
        check_csr("mcause ext", `CSR_MCAUSE, 32'h8000_000b);
        check_csr("mepc", `CSR_MEPC, {pc[31:2], 2'b00});
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MSTATUS, 32'h8);
        #10;
        check_value("timer taken", 32'h1, {31'h0, trap_taken});
        @(negedge clk);
        m_timer_irq = 1'b0;
        check_csr("mcause timer", `CSR_MCAUSE, 32'h8000_0007);
        end_test();

        start_test("mret");
        m_mepc = rand_bits(32);
        m_mepc[1:0] = 2'b00;
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MEPC, m_mepc);
        write_csr(csr_pkg::CSR_OP_WRITE, `CSR_MSTATUS, 32'h80);  // MPP U with MPIE set
        @(negedge clk);
        mret = 1'b1;
        #10;
        check_value("redirect_valid", 32'h1, {31'h0, redirect_valid});
        check_value("redirect_pc", m_mepc, redirect_pc);
        @(negedge clk);
        mret = 1'b0;
        check_value("mode U", 32'h0, {30'h0, current_mode});
        check_csr("mstatus", `CSR_MSTATUS, 32'h88);
        // trap from U and return to U
        @(negedge clk);
        exc_valid = 1'b1;
        exc_cause = 32'd8;
        exc_pc    = m_mepc;
        exc_tval  = 32'h0;
        @(negedge clk);
        exc_valid = 1'b0;
        check_value("mode M", 32'h3, {30'h0, current_mode});
        check_csr("mstatus U trap", `CSR_MSTATUS, 32'h80);
        @(negedge clk);
        mret = 1'b1;
        @(negedge clk);
        mret = 1'b0;
        check_value("back to U", 32'h0, {30'h0, current_mode});
        check_csr("mstatus after", `CSR_MSTATUS, 32'h88);
        end_test();

        error_count += dut.u_assertions.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_count, check_count, error_count, dut.u_assertions.fail_count);
        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
